// File: alu.sv
`timescale 1ns/1ps

module alu (
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  input  cpu_pkg::alu_op_t op,
  output cpu_pkg::word_t   result,
  output cpu_pkg::flags_t  flags
);

  cpu_pkg::word_t sum;
  cpu_pkg::word_t diff;
  logic           add_ovf;
  logic           sub_ovf;
  logic           ovf;
  // Shift and rotate amount
  logic [3:0]     shamt;
  // Doubled operand for rotate
  logic [31:0]    ror_wide;

  assign shamt = b[3:0];
  assign sum   = a + b;
  assign diff  = a - b;

  // Add overflows when the operands agree in sign and the sum does not
  assign add_ovf = (a[15] == b[15]) && (sum[15] != a[15]);
  // Subtract overflows when the signs differ and the result flips from a
  assign sub_ovf = (a[15] != b[15]) && (diff[15] != a[15]);

  assign ror_wide = {a, a} >> shamt;

  always_comb begin
    ovf    = 1'b0;
    result = a;
    case (op)
      cpu_pkg::ALU_ADD: begin
        ovf = add_ovf;
        // Saturate toward the sign of a
        result = add_ovf ? (a[15] ? 16'h8000 : 16'h7fff) : sum;
      end
      cpu_pkg::ALU_SUB: begin
        ovf = sub_ovf;
        result = sub_ovf ? (a[15] ? 16'h8000 : 16'h7fff) : diff;
      end
      cpu_pkg::ALU_XOR: result = a ^ b;
      cpu_pkg::ALU_SLL: result = a << shamt;
      // Arithmetic shift keeps the sign bit
      cpu_pkg::ALU_SRA: result = $signed(a) >>> shamt;
      cpu_pkg::ALU_ROR: result = ror_wide[15:0];
      cpu_pkg::ALU_PASS: result = a;
      default: result = a;
    endcase
  end

  // Raw flags; flag_unit picks which ones stick
  assign flags.n = result[15];
  assign flags.v = ovf;
  assign flags.z = (result == '0);

endmodule

// File: control.sv
`timescale 1ns/1ps

module control (
  input  cpu_pkg::opcode_t opcode,
  output cpu_pkg::ctrl_t   ctrl
);

  always_comb begin
    // Everything idle unless the opcode says otherwise
    ctrl = '0;
    case (opcode)
      cpu_pkg::OP_ADD: begin
        ctrl.regwrite = 1'b1;
        ctrl.alu_op   = cpu_pkg::ALU_ADD;
      end
      cpu_pkg::OP_SUB: begin
        ctrl.regwrite = 1'b1;
        ctrl.alu_op   = cpu_pkg::ALU_SUB;
      end
      cpu_pkg::OP_XOR: begin
        ctrl.regwrite = 1'b1;
        ctrl.alu_op   = cpu_pkg::ALU_XOR;
      end
      // Shifts take the amount from imm4
      cpu_pkg::OP_SLL, cpu_pkg::OP_SRA, cpu_pkg::OP_ROR: begin
        ctrl.regwrite    = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.imm_kind    = cpu_pkg::IMM_SHAMT4;
        ctrl.alu_op      = (opcode == cpu_pkg::OP_SLL) ? cpu_pkg::ALU_SLL :
                           (opcode == cpu_pkg::OP_SRA) ? cpu_pkg::ALU_SRA :
                                                         cpu_pkg::ALU_ROR;
      end
      cpu_pkg::OP_LW: begin
        ctrl.regwrite   = 1'b1;
        ctrl.imm_kind   = cpu_pkg::IMM_SEXT4;
        ctrl.mem_read   = 1'b1;
        ctrl.mem_to_reg = 1'b1;
      end
      // Stores rd, read through port 1
      cpu_pkg::OP_SW: begin
        ctrl.imm_kind  = cpu_pkg::IMM_SEXT4;
        ctrl.mem_write = 1'b1;
      end
      cpu_pkg::OP_LLB, cpu_pkg::OP_LHB: begin
        ctrl.regwrite  = 1'b1;
        ctrl.imm_kind  = cpu_pkg::IMM_BYTE8;
        ctrl.byte_load = (opcode == cpu_pkg::OP_LLB) ? cpu_pkg::BYTE_LOW :
                                                       cpu_pkg::BYTE_HIGH;
      end
      cpu_pkg::OP_B:  ctrl.branch = cpu_pkg::BRANCH_IMM;
      cpu_pkg::OP_BR: ctrl.branch = cpu_pkg::BRANCH_REG;
      cpu_pkg::OP_PCS: begin
        ctrl.regwrite  = 1'b1;
        ctrl.pc_to_reg = 1'b1;
      end
      cpu_pkg::OP_HLT: ctrl.halt = 1'b1;
      // Opcodes 3 and 7 fall through as no-ops
      default: ctrl = '0;
    endcase
  end

endmodule

// File: cpu.sv
`timescale 1ns/1ps

module cpu (
  input  logic             clk,
  input  logic             reset,
  input  cpu_pkg::load_t   prog,
  output cpu_pkg::word_t   pc,
  output logic             hlt,
  output cpu_pkg::retire_t retire
);

  cpu_pkg::word_t                      instr;
  cpu_pkg::reg_addr_t                  rd;
  cpu_pkg::reg_addr_t                  rs;
  cpu_pkg::reg_addr_t                  rt;
  cpu_pkg::reg_addr_t                  src1;
  cpu_pkg::reg_addr_t                  src2;
  cpu_pkg::ctrl_t                      ctrl;
  cpu_pkg::word_t                      src1_data;
  cpu_pkg::word_t                      src2_data;
  cpu_pkg::word_t                      imm_ext;
  cpu_pkg::word_t                      alu_b;
  cpu_pkg::word_t                      alu_result;
  cpu_pkg::word_t                      mem_addr;
  cpu_pkg::word_t                      mem_rdata;
  cpu_pkg::word_t                      byte_merge;
  cpu_pkg::word_t                      wb_data;
  cpu_pkg::word_t                      next_pc;
  cpu_pkg::word_t                      pc_plus2;
  cpu_pkg::flags_t                     alu_flags;
  cpu_pkg::flags_t                     flags;
  logic [cpu_pkg::IMEM_ADDR_WIDTH-1:0] imem_addr;
  logic                                imem_write;
  logic                                dmem_write;
  logic                                flag_update;

  // PC register
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

  // Fetch; the load port owns imem only while reset is high
  assign imem_write = reset && prog.en;
  assign imem_addr  = imem_write ? prog.addr : pc[cpu_pkg::IMEM_ADDR_WIDTH:1];

  memory #(
    .ADDR_WIDTH(cpu_pkg::IMEM_ADDR_WIDTH)
  ) imem (
    .clk   (clk),
    .reset (reset),
    .addr  (imem_addr),
    .wdata (prog.data),
    .write (imem_write),
    .rdata (instr)
  );

  // Decode
  control i_control (
    .opcode (cpu_pkg::opcode_t'(instr[15:12])),
    .ctrl   (ctrl)
  );

  assign rd = instr[11:8];
  assign rs = instr[7:4];
  assign rt = instr[3:0];
  // SW, LLB and LHB read rd on port 1
  assign src1 = (ctrl.mem_write || (ctrl.byte_load != cpu_pkg::BYTE_NONE)) ? rd : rs;
  // SW has no rt, so port 2 fetches its base register
  assign src2 = ctrl.mem_write ? rs : rt;

  register_file i_register_file (
    .clk       (clk),
    .reset     (reset),
    .src1      (src1),
    .src2      (src2),
    .dst       (rd),
    .write     (ctrl.regwrite),
    .dst_data  (wb_data),
    .src1_data (src1_data),
    .src2_data (src2_data)
  );

  // Immediate extension
  always_comb begin
    case (ctrl.imm_kind)
      // Memory offset sign-extended and doubled to bytes
      cpu_pkg::IMM_SEXT4:  imm_ext = {{11{instr[3]}}, instr[3:0], 1'b0};
      cpu_pkg::IMM_SHAMT4: imm_ext = {12'h000, instr[3:0]};
      cpu_pkg::IMM_BYTE8:  imm_ext = {8'h00, instr[7:0]};
      default:             imm_ext = '0;
    endcase
  end

  // Execute
  assign alu_b = ctrl.alu_src_imm ? imm_ext : src2_data;

  alu i_alu (
    .a      (src1_data),
    .b      (alu_b),
    .op     (ctrl.alu_op),
    .result (alu_result),
    .flags  (alu_flags)
  );

  // Only register-writing ALU ops touch the flags
  assign flag_update = ctrl.regwrite && !ctrl.mem_read && !ctrl.pc_to_reg &&
                       (ctrl.byte_load == cpu_pkg::BYTE_NONE);

  flag_unit i_flag_unit (
    .clk       (clk),
    .reset     (reset),
    .op        (ctrl.alu_op),
    .alu_flags (alu_flags),
    .update    (flag_update),
    .flags     (flags)
  );

  pc_control i_pc_control (
    .pc       (pc),
    .branch   (ctrl.branch),
    .halt     (ctrl.halt),
    .cond     (cpu_pkg::cond_t'(instr[11:9])),
    .offset   (instr[8:0]),
    .target   (src1_data),
    .flags    (flags),
    .next_pc  (next_pc),
    .pc_plus2 (pc_plus2)
  );

  // Memory takes the byte address with bit 0 dropped
  assign mem_addr   = (ctrl.mem_write ? src2_data : src1_data) + imm_ext;
  assign dmem_write = ctrl.mem_write && !reset;

  memory #(
    .ADDR_WIDTH(cpu_pkg::DMEM_ADDR_WIDTH)
  ) dmem (
    .clk   (clk),
    .reset (reset),
    .addr  (mem_addr[cpu_pkg::DMEM_ADDR_WIDTH:1]),
    .wdata (src1_data),
    .write (dmem_write),
    .rdata (mem_rdata)
  );

  // Write-back; LLB/LHB keep the other byte of rd
  assign byte_merge = (ctrl.byte_load == cpu_pkg::BYTE_LOW) ?
                      {src1_data[15:8], imm_ext[7:0]} :
                      {imm_ext[7:0], src1_data[7:0]};

  assign wb_data = ctrl.pc_to_reg ? pc_plus2 :
                   ctrl.mem_to_reg ? mem_rdata :
                   (ctrl.byte_load != cpu_pkg::BYTE_NONE) ? byte_merge :
                   alu_result;

  // Trace of the write in this cycle
  assign retire.valid = ctrl.regwrite && (rd != '0) && !reset && !ctrl.halt;
  assign retire.rd    = rd;
  assign retire.data  = wb_data;
  assign retire.pc    = pc;

  assign hlt = ctrl.halt;

endmodule

// File: cpu_pkg.sv
package cpu_pkg;

  // Data, address and instruction word
  typedef logic [15:0] word_t;
  // Register index, 16 registers
  typedef logic [3:0] reg_addr_t;
  typedef logic [3:0] opcode_t;
  // Branch condition from instr[11:9]
  typedef logic [2:0] cond_t;
  typedef logic [2:0] alu_op_t;
  typedef logic [1:0] imm_kind_t;
  typedef logic [1:0] byte_load_t;
  typedef logic [1:0] branch_t;

  // Opcodes, 3 and 7 unused
  localparam opcode_t OP_ADD = 4'h0;
  localparam opcode_t OP_SUB = 4'h1;
  localparam opcode_t OP_XOR = 4'h2;
  localparam opcode_t OP_SLL = 4'h4;
  localparam opcode_t OP_SRA = 4'h5;
  localparam opcode_t OP_ROR = 4'h6;
  localparam opcode_t OP_LW  = 4'h8;
  localparam opcode_t OP_SW  = 4'h9;
  localparam opcode_t OP_LLB = 4'ha;
  localparam opcode_t OP_LHB = 4'hb;
  localparam opcode_t OP_B   = 4'hc;
  localparam opcode_t OP_BR  = 4'hd;
  localparam opcode_t OP_PCS = 4'he;
  localparam opcode_t OP_HLT = 4'hf;

  // Branch conditions
  localparam cond_t COND_NE = 3'd0;
  localparam cond_t COND_EQ = 3'd1;
  localparam cond_t COND_GT = 3'd2;
  localparam cond_t COND_LT = 3'd3;
  localparam cond_t COND_GE = 3'd4;
  localparam cond_t COND_LE = 3'd5;
  localparam cond_t COND_OV = 3'd6;
  localparam cond_t COND_AL = 3'd7;

  // ALU functions, zero is the idle pass-through
  localparam alu_op_t ALU_PASS = 3'd0;
  localparam alu_op_t ALU_ADD  = 3'd1;
  localparam alu_op_t ALU_SUB  = 3'd2;
  localparam alu_op_t ALU_XOR  = 3'd3;
  localparam alu_op_t ALU_SLL  = 3'd4;
  localparam alu_op_t ALU_SRA  = 3'd5;
  localparam alu_op_t ALU_ROR  = 3'd6;

  // Immediate forms
  localparam imm_kind_t IMM_SEXT4  = 2'd0;
  localparam imm_kind_t IMM_SHAMT4 = 2'd1;
  localparam imm_kind_t IMM_BYTE8  = 2'd2;

  localparam byte_load_t BYTE_NONE = 2'd0;
  localparam byte_load_t BYTE_LOW  = 2'd1;
  localparam byte_load_t BYTE_HIGH = 2'd2;

  localparam branch_t BRANCH_NONE = 2'd0;
  localparam branch_t BRANCH_IMM  = 2'd1;
  localparam branch_t BRANCH_REG  = 2'd2;

  // Word-address widths of the two memories
  localparam int IMEM_ADDR_WIDTH = 8;
  localparam int DMEM_ADDR_WIDTH = 8;

  typedef struct packed {
    logic n;
    logic v;
    logic z;
  } flags_t;

  typedef struct packed {
    logic       regwrite;
    alu_op_t    alu_op;
    logic       alu_src_imm;
    imm_kind_t  imm_kind;
    logic       mem_read;
    logic       mem_write;
    logic       mem_to_reg;
    logic       pc_to_reg;
    byte_load_t byte_load;
    branch_t    branch;
    logic       halt;
  } ctrl_t;

  // Program-load port into instruction memory
  typedef struct packed {
    logic                       en;
    logic [IMEM_ADDR_WIDTH-1:0] addr;
    word_t                      data;
  } load_t;

  // Write-back trace record
  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    word_t     data;
    word_t     pc;
  } retire_t;

endpackage

// File: flag_unit.sv
`timescale 1ns/1ps

module flag_unit (
  input  logic             clk,
  input  logic             reset,
  input  cpu_pkg::alu_op_t op,
  input  cpu_pkg::flags_t  alu_flags,
  input  logic             update,
  output cpu_pkg::flags_t  flags
);

  // Bits of the flag register this op may write
  cpu_pkg::flags_t mask;

  always_comb begin
    mask = '0;
    case (op)
      // Arithmetic writes all three
      cpu_pkg::ALU_ADD, cpu_pkg::ALU_SUB: mask = '1;
      // Logic and shifts only touch Z
      cpu_pkg::ALU_XOR, cpu_pkg::ALU_SLL,
      cpu_pkg::ALU_SRA, cpu_pkg::ALU_ROR: mask.z = 1'b1;
      default: mask = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (update) begin
      flags <= (alu_flags & mask) | (flags & ~mask);
    end
  end

endmodule

// File: memory.sv
`timescale 1ns/1ps

module memory #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [ADDR_WIDTH-1:0] addr,
  input  cpu_pkg::word_t        wdata,
  input  logic                  write,
  output cpu_pkg::word_t        rdata
);

  // Word storage
  cpu_pkg::word_t mem [2**ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (write) begin
      mem[addr] <= wdata;
    end
  end

  // Combinational read
  assign rdata = mem[addr];

endmodule

// File: pc_control.sv
`timescale 1ns/1ps

module pc_control (
  input  cpu_pkg::word_t   pc,
  input  cpu_pkg::branch_t branch,
  input  logic             halt,
  input  cpu_pkg::cond_t   cond,
  input  logic [8:0]       offset,
  input  cpu_pkg::word_t   target,
  input  cpu_pkg::flags_t  flags,
  output cpu_pkg::word_t   next_pc,
  output cpu_pkg::word_t   pc_plus2
);

  logic           taken;
  cpu_pkg::word_t branch_pc;

  assign pc_plus2 = pc + 16'd2;
  // Offset counts words, so sign-extend and double
  assign branch_pc = pc_plus2 + {{6{offset[8]}}, offset, 1'b0};

  // Condition table against the current flags
  always_comb begin
    taken = 1'b0;
    case (cond)
      cpu_pkg::COND_NE: taken = !flags.z;
      cpu_pkg::COND_EQ: taken = flags.z;
      cpu_pkg::COND_GT: taken = !flags.z && !flags.n;
      cpu_pkg::COND_LT: taken = flags.n;
      cpu_pkg::COND_GE: taken = flags.z || !flags.n;
      cpu_pkg::COND_LE: taken = flags.z || flags.n;
      cpu_pkg::COND_OV: taken = flags.v;
      cpu_pkg::COND_AL: taken = 1'b1;
    endcase
  end

  always_comb begin
    if (halt) begin
      // HLT parks the PC on itself
      next_pc = pc;
    end else if (taken && (branch == cpu_pkg::BRANCH_IMM)) begin
      next_pc = branch_pc;
    end else if (taken && (branch == cpu_pkg::BRANCH_REG)) begin
      next_pc = target;
    end else begin
      next_pc = pc_plus2;
    end
  end

endmodule

// File: project.f
cpu_pkg.sv
memory.sv
register_file.sv
alu.sv
flag_unit.sv
control.sv
pc_control.sv
cpu.sv
tb_cpu.sv

// File: register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic               clk,
  input  logic               reset,
  input  cpu_pkg::reg_addr_t src1,
  input  cpu_pkg::reg_addr_t src2,
  input  cpu_pkg::reg_addr_t dst,
  input  logic               write,
  input  cpu_pkg::word_t     dst_data,
  output cpu_pkg::word_t     src1_data,
  output cpu_pkg::word_t     src2_data
);

  cpu_pkg::word_t regs [16];

  // All registers clear on reset
  // Writes to r0 are dropped
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (write && (dst != '0)) begin
      regs[dst] <= dst_data;
    end
  end

  // Combinational reads, r0 hardwired to zero
  assign src1_data = (src1 == '0) ? '0 : regs[src1];
  assign src2_data = (src2 == '0) ? '0 : regs[src2];

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_cpu \
  --Mdir obj_dir -o tb_cpu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/tb_cpu_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see sim.log"
  exit 1
fi

if grep -qx "TEST PASS" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// File: tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

  // Cycle budget for one program to reach HLT
  localparam int RUN_LIMIT = 1000;

  logic             clk;
  logic             reset;
  cpu_pkg::load_t   prog;
  cpu_pkg::word_t   pc;
  logic             hlt;
  cpu_pkg::retire_t retire;

  // Program image and the expected retire stream
  cpu_pkg::word_t     prog_words [$];
  cpu_pkg::reg_addr_t exp_rd [$];
  cpu_pkg::word_t     exp_data [$];
  cpu_pkg::word_t     exp_pc [$];
  cpu_pkg::word_t     exp_halt_pc;

  // Reference model state
  cpu_pkg::word_t mregs [16];
  cpu_pkg::word_t mdmem [int];
  logic           mn;
  logic           mv;
  logic           mz;
  // Next word sits in a taken branch's shadow
  logic           skip_next;

  logic [31:0] lcg_state;
  int          n_checks;
  int          n_errors;

  cpu i_dut (
    .clk    (clk),
    .reset  (reset),
    .prog   (prog),
    .pc     (pc),
    .hlt    (hlt),
    .retire (retire)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic cpu_pkg::word_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] time %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Exact signed sum or difference clamped to 16 bits with V in bit 16
  function automatic logic [16:0] sat_arith(cpu_pkg::word_t a, cpu_pkg::word_t b, logic sub);
    int sa;
    int sb;
    int r;
    sa = int'($signed(a));
    sb = int'($signed(b));
    r  = sub ? sa - sb : sa + sb;
    if (r > 32767) begin
      return {1'b1, 16'h7fff};
    end else if (r < -32768) begin
      return {1'b1, 16'h8000};
    end
    return {1'b0, r[15:0]};
  endfunction

  function automatic cpu_pkg::word_t shift_model(cpu_pkg::opcode_t op, cpu_pkg::word_t a,
                                                 int s);
    int          sa;
    logic [31:0] w;
    sa = int'($signed(a));
    if (op == cpu_pkg::OP_SLL) begin
      w = {16'h0, a} << s;
    end else if (op == cpu_pkg::OP_SRA) begin
      w = sa >>> s;
    end else begin
      // Rotate brings the bits shifted out back in at the top
      w = ({16'h0, a} >> s) | ({16'h0, a} << (16 - s));
    end
    return w[15:0];
  endfunction

  function automatic logic cond_holds(cpu_pkg::cond_t c);
    logic t;
    case (c)
      cpu_pkg::COND_NE: t = !mz;
      cpu_pkg::COND_EQ: t = mz;
      cpu_pkg::COND_GT: t = !mz && !mn;
      cpu_pkg::COND_LT: t = mn;
      cpu_pkg::COND_GE: t = mz || !mn;
      cpu_pkg::COND_LE: t = mz || mn;
      cpu_pkg::COND_OV: t = mv;
      default:          t = 1'b1;
    endcase
    return t;
  endfunction

  // Returns low when the word is jumped over
  function automatic logic append_word(cpu_pkg::word_t w);
    logic runs;
    runs      = !skip_next;
    skip_next = 1'b0;
    prog_words.push_back(w);
    return runs;
  endfunction

  function automatic cpu_pkg::word_t next_addr();
    return cpu_pkg::word_t'(prog_words.size() * 2);
  endfunction

  task automatic record_write(cpu_pkg::reg_addr_t rd, cpu_pkg::word_t val,
                              cpu_pkg::word_t ipc);
    // r0 never retires
    if (rd != '0) begin
      mregs[rd] = val;
      exp_rd.push_back(rd);
      exp_data.push_back(val);
      exp_pc.push_back(ipc);
    end
  endtask

  task automatic start_program();
    int i;
    prog_words.delete();
    exp_rd.delete();
    exp_data.delete();
    exp_pc.delete();
    mdmem.delete();
    for (i = 0; i < 16; i++) begin
      mregs[i] = '0;
    end
    mn        = 1'b0;
    mv        = 1'b0;
    mz        = 1'b0;
    skip_next = 1'b0;
    // Word 0 is a no-op that runs while reset is being released
    void'(append_word(16'h3000));
  endtask

  task automatic byte_load_instr(logic high, cpu_pkg::reg_addr_t rd, logic [7:0] imm8);
    cpu_pkg::word_t ipc;
    cpu_pkg::word_t v;
    ipc = next_addr();
    v   = mregs[rd];
    if (append_word({(high ? cpu_pkg::OP_LHB : cpu_pkg::OP_LLB), rd, imm8})) begin
      if (high) begin
        v[15:8] = imm8;
      end else begin
        v[7:0] = imm8;
      end
      record_write(rd, v, ipc);
    end
  endtask

  task automatic word_into(cpu_pkg::reg_addr_t rd, cpu_pkg::word_t val);
    byte_load_instr(1'b0, rd, val[7:0]);
    byte_load_instr(1'b1, rd, val[15:8]);
  endtask

  task automatic alu_instr(cpu_pkg::opcode_t op, cpu_pkg::reg_addr_t rd,
                           cpu_pkg::reg_addr_t rs, logic [3:0] rt);
    cpu_pkg::word_t ipc;
    cpu_pkg::word_t a;
    cpu_pkg::word_t b;
    cpu_pkg::word_t r;
    logic [16:0]    sr;
    ipc = next_addr();
    a   = mregs[rs];
    b   = mregs[rt];
    if (append_word({op, rd, rs, rt})) begin
      if (op == cpu_pkg::OP_ADD || op == cpu_pkg::OP_SUB) begin
        sr = sat_arith(a, b, op == cpu_pkg::OP_SUB);
        r  = sr[15:0];
        mv = sr[16];
        mn = r[15];
      end else if (op == cpu_pkg::OP_XOR) begin
        r = a ^ b;
      end else begin
        r = shift_model(op, a, int'(rt));
      end
      // Every ALU op writes Z
      mz = (r == '0);
      record_write(rd, r, ipc);
    end
  endtask

  task automatic mem_instr(logic store, cpu_pkg::reg_addr_t rd, cpu_pkg::reg_addr_t rs,
                           logic [3:0] off);
    cpu_pkg::word_t ipc;
    int             addr;
    int             idx;
    ipc  = next_addr();
    // Byte address with the offset counted in words
    addr = int'(mregs[rs]) + 2 * int'($signed(off));
    idx  = (addr >> 1) & 255;
    if (append_word({(store ? cpu_pkg::OP_SW : cpu_pkg::OP_LW), rd, rs, off})) begin
      if (store) begin
        mdmem[idx] = mregs[rd];
      end else begin
        record_write(rd, mdmem.exists(idx) ? mdmem[idx] : 16'h0000, ipc);
      end
    end
  endtask

  // Either form skips exactly one word when taken
  task automatic branch_instr(logic use_reg, cpu_pkg::cond_t c, cpu_pkg::reg_addr_t rs);
    cpu_pkg::word_t w;
    if (use_reg) begin
      w = {cpu_pkg::OP_BR, c, 1'b0, rs, 4'h0};
    end else begin
      w = {cpu_pkg::OP_B, c, 9'd1};
    end
    if (append_word(w)) begin
      skip_next = cond_holds(c);
    end
  endtask

  task automatic pcs_instr(cpu_pkg::reg_addr_t rd);
    cpu_pkg::word_t ipc;
    ipc = next_addr();
    if (append_word({cpu_pkg::OP_PCS, rd, 8'h00})) begin
      record_write(rd, ipc + 16'd2, ipc);
    end
  endtask

  task automatic halt_instr();
    exp_halt_pc = next_addr();
    void'(append_word({cpu_pkg::OP_HLT, 12'h000}));
  endtask

  task automatic load_program();
    int n;
    int cyc;
    @(negedge clk);
    reset = 1'b1;
    prog  = '0;
    // Two reset cycles before the load starts
    repeat (2) @(negedge clk);
    cyc = 2;
    for (n = 0; n < prog_words.size(); n++) begin
      prog.en   = 1'b1;
      prog.addr = n[7:0];
      prog.data = prog_words[n];
      @(negedge clk);
      cyc++;
    end
    while (cyc < 8) begin
      @(negedge clk);
      cyc++;
    end
    check_value("pc during reset", pc, 16'h0000);
    check_value("retire.valid during reset", 16'(retire.valid), 16'h0000);
    prog  = '0;
    reset = 1'b0;
  endtask

  task automatic compare_retire();
    if (exp_rd.size() == 0) begin
      n_errors++;
      $display("Unexpected write to r%0d retired at pc %h", retire.rd, retire.pc);
    end else begin
      check_value("retire.rd", 16'(retire.rd), 16'(exp_rd.pop_front()));
      check_value("retire.data", retire.data, exp_data.pop_front());
      check_value("retire.pc", retire.pc, exp_pc.pop_front());
    end
  endtask

  // Samples at each falling edge until HLT shows up
  task automatic run_program();
    int   cyc;
    logic done;
    cyc  = 0;
    done = 1'b0;
    while (!done && cyc < RUN_LIMIT) begin
      @(negedge clk);
      cyc++;
      if (hlt) begin
        done = 1'b1;
      end else if (retire.valid) begin
        compare_retire();
      end
    end
    if (!done) begin
      n_errors++;
      $display("Timeout: program did not reach HLT within %0d cycles", RUN_LIMIT);
    end else begin
      check_value("pc at halt", pc, exp_halt_pc);
      if (exp_rd.size() != 0) begin
        n_errors++;
        $display("%0d expected register writes never retired", exp_rd.size());
      end
    end
  endtask

  task automatic arith_pair(cpu_pkg::word_t a, cpu_pkg::word_t b);
    word_into(4'd1, a);
    word_into(4'd2, b);
    alu_instr(cpu_pkg::OP_ADD, 4'd3, 4'd1, 4'd2);
    alu_instr(cpu_pkg::OP_SUB, 4'd4, 4'd1, 4'd2);
  endtask

  task automatic arithmetic_checks();
    int i;
    start_program();
    // Edges of the saturation range
    arith_pair(16'h7fff, 16'h0001);
    arith_pair(16'h8000, 16'h0001);
    arith_pair(16'h8000, 16'h8000);
    arith_pair(16'h7fff, 16'hffff);
    for (i = 0; i < 20; i++) begin
      arith_pair(lcg_next(), lcg_next());
    end
    halt_instr();
    load_program();
    run_program();
  endtask

  task automatic logic_shift_checks();
    int i;
    int s;
    start_program();
    for (i = 0; i < 2; i++) begin
      word_into(4'd1, lcg_next());
      word_into(4'd2, lcg_next());
      alu_instr(cpu_pkg::OP_XOR, 4'd3, 4'd1, 4'd2);
      alu_instr(cpu_pkg::OP_XOR, 4'd7, 4'd1, 4'd1);
      for (s = 0; s < 16; s++) begin
        alu_instr(cpu_pkg::OP_SLL, 4'd4, 4'd1, s[3:0]);
        alu_instr(cpu_pkg::OP_SRA, 4'd5, 4'd1, s[3:0]);
        alu_instr(cpu_pkg::OP_ROR, 4'd6, 4'd1, s[3:0]);
      end
    end
    halt_instr();
    load_program();
    run_program();
  endtask

  task automatic memory_checks();
    logic [3:0] offs [7];
    int         i;
    offs = '{4'h8, 4'hb, 4'hf, 4'h0, 4'h1, 4'h3, 4'h7};
    start_program();
    // Base 0x0040 sits mid-memory so negative offsets stay in range
    byte_load_instr(1'b0, 4'd1, 8'h40);
    for (i = 0; i < 7; i++) begin
      word_into(4'd2, lcg_next());
      mem_instr(1'b1, 4'd2, 4'd1, offs[i]);
    end
    for (i = 0; i < 7; i++) begin
      mem_instr(1'b0, cpu_pkg::reg_addr_t'(i + 3), 4'd1, offs[i]);
    end
    halt_instr();
    load_program();
    run_program();
  endtask

  task automatic branch_checks();
    int             c;
    int             k;
    cpu_pkg::word_t tgt;
    start_program();
    word_into(4'd1, 16'h7fff);
    byte_load_instr(1'b0, 4'd2, 8'd1);
    byte_load_instr(1'b0, 4'd3, 8'd5);
    byte_load_instr(1'b0, 4'd4, 8'd9);
    // Data word 0 feeds the loads below
    mem_instr(1'b1, 4'd4, 4'd0, 4'h0);
    for (c = 0; c < 8; c++) begin
      for (k = 0; k < 4; k++) begin
        // Flags from a zero, negative, positive and overflowing result
        case (k)
          0:       alu_instr(cpu_pkg::OP_SUB, 4'd5, 4'd3, 4'd3);
          1:       alu_instr(cpu_pkg::OP_SUB, 4'd5, 4'd3, 4'd4);
          2:       alu_instr(cpu_pkg::OP_SUB, 4'd5, 4'd4, 4'd3);
          default: alu_instr(cpu_pkg::OP_ADD, 4'd5, 4'd1, 4'd2);
        endcase
        // Load in between must leave the flags alone
        mem_instr(1'b0, 4'd8, 4'd0, 4'h0);
        if (((c + k) % 2) == 1) begin
          // Target is the PCS past the shadow word
          tgt = next_addr() + 16'd8;
          word_into(4'd14, tgt);
          branch_instr(1'b1, cpu_pkg::cond_t'(c), 4'd14);
        end else begin
          branch_instr(1'b0, cpu_pkg::cond_t'(c), 4'd0);
        end
        byte_load_instr(1'b0, 4'd9, 8'(c * 4 + k));
        pcs_instr(4'd10);
      end
    end
    halt_instr();
    load_program();
    run_program();
  endtask

  task automatic halt_reset_checks();
    int             i;
    cpu_pkg::word_t held_pc;
    start_program();
    word_into(4'd1, 16'h1234);
    alu_instr(cpu_pkg::OP_ADD, 4'd2, 4'd1, 4'd1);
    halt_instr();
    load_program();
    run_program();
    held_pc = pc;
    for (i = 0; i < 20; i++) begin
      @(negedge clk);
      check_value("pc while halted", pc, held_pc);
      check_value("hlt while halted", 16'(hlt), 16'h0001);
      check_value("retire.valid while halted", 16'(retire.valid), 16'h0000);
    end
    // r1 must read zero after the second reset
    start_program();
    pcs_instr(4'd3);
    alu_instr(cpu_pkg::OP_ADD, 4'd4, 4'd1, 4'd1);
    halt_instr();
    load_program();
    run_program();
  endtask

  initial begin
    reset     = 1'b1;
    prog      = '0;
    lcg_state = 32'd92521;
    n_checks  = 0;
    n_errors  = 0;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    arithmetic_checks();
    logic_shift_checks();
    memory_checks();
    branch_checks();
    halt_reset_checks();
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
